//--- files.f
source/memBusPkg.sv
source/lc3IsaPkg.sv
source/apbFrontEnd.sv
source/memCore.sv
source/sramTestMemory.sv
dv/memScoreboard.sv
dv/tbSramTestMemory.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log for the fail message

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert -j 0 --top-module tbSramTestMemory -f files.f -o simTb \
   && ./obj_dir/simTb > "$LOG" 2>&1 \
   || { echo "build or simulation did not complete"; cat "$LOG" 2>/dev/null; exit 1; }

cat "$LOG"
grep -q "tests failed" "$LOG" \
   && { echo "simulation reported failures"; exit 1; } \
   || { echo "no failures in $LOG"; exit 0; }

//--- dv/tbSramTestMemory.sv
// Testbench top with clock, reset, APB driver tasks, test sequence and watchdog

`timescale 1ns/100ps

module tbSramTestMemory;

   localparam int Depth         = 256;
   localparam int WritableWords = 64;
   localparam int ClkPeriod     = 4;                 // ns
   localparam int ResetCycles   = 16;
   localparam int BootSamples   = 12;                // Probes above the boot image
   localparam int FullWrites    = 8;
   localparam int StrbWords     = 4;
   localparam int RandomOps     = 200;
   localparam int AfterReset    = 32;                // Reads after the mid-run reset
   localparam int NumTransfers  = lc3IsaPkg::BootWords + BootSamples + 1 + 2*FullWrites
                                  + 5*StrbWords + 8 + 3 + RandomOps + AfterReset;
   // Three cycles per transfer plus one idle, two resets and some slack
   localparam int TimeoutNs     = (NumTransfers*4 + 2*ResetCycles + 100) * ClkPeriod;

   logic                Clk;
   logic                Reset;
   logic                psel;
   logic                penable;
   logic                pwrite;
   memBusPkg::memAddrT  paddr;
   memBusPkg::memWordT  pwdata;
   memBusPkg::byteStrbT pstrb;
   memBusPkg::memWordT  prdata;
   logic                pready;
   logic                pslverr;

   int checkTotal;                                   // From the scoreboard
   int errTotal;
   int testNo;
   int testChecks;                                   // Totals at start of current test
   int testErrs;

   sramTestMemory #(.Depth(Depth), .WritableWords(WritableWords)) uut
   (
      .Clk     (Clk),
      .Reset   (Reset),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .pstrb   (pstrb),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr)
   );

   memScoreboard #(.Depth(Depth), .WritableWords(WritableWords)) scoreboard
   (
      .Clk        (Clk),
      .Reset      (Reset),
      .psel       (psel),
      .penable    (penable),
      .pwrite     (pwrite),
      .paddr      (paddr),
      .pwdata     (pwdata),
      .pstrb      (pstrb),
      .prdata     (prdata),
      .pready     (pready),
      .pslverr    (pslverr),
      .checkCount (checkTotal),
      .errCount   (errTotal)
   );

   initial
   begin
      Clk = 1'b0;
      forever #(ClkPeriod/2) Clk = ~Clk;
   end

   // ------------------------------------------------------------
   // APB driver
   // ------------------------------------------------------------
   task automatic runTransfer(input logic write, input memBusPkg::memAddrT addr,
                              input memBusPkg::memWordT data, input memBusPkg::byteStrbT strb);
      @(posedge Clk);
      psel    <= 1'b1;                               // Setup cycle
      penable <= 1'b0;
      pwrite  <= write;
      paddr   <= addr;
      pwdata  <= data;
      pstrb   <= strb;
      @(posedge Clk);
      penable <= 1'b1;                               // Access until pready
      @(posedge Clk);
      while (!pready)
         @(posedge Clk);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic readWord(input memBusPkg::memAddrT addr);
      runTransfer(1'b0, addr, '0, '0);
   endtask

   task automatic writeWord(input memBusPkg::memAddrT addr, input memBusPkg::memWordT data,
                            input memBusPkg::byteStrbT strb);
      runTransfer(1'b1, addr, data, strb);
   endtask

   task automatic tryLockedWrite(input memBusPkg::memAddrT addr);
      writeWord(addr, 16'hFFFF, 2'b11);              // Expect an error response
      readWord(addr);                                // Word must be unchanged
   endtask

   task automatic pulseReset();
      @(posedge Clk);
      Reset <= 1'b1;
      repeat (ResetCycles) @(posedge Clk);
      Reset <= 1'b0;
   endtask

   task automatic reportTest(input string name);
      int checks;
      int errs;
      @(posedge Clk);                                // Last compare has landed
      checks = checkTotal - testChecks;
      errs   = errTotal - testErrs;
      testNo++;
      if (errs == 0)
         $display("test %0d %s: %0d checks ok", testNo, name, checks);
      else
         $display("test %0d %s: %0d of %0d checks wrong", testNo, name, errs, checks);
      testChecks = checkTotal;
      testErrs   = errTotal;
   endtask

   // ------------------------------------------------------------
   // Test sequence
   // ------------------------------------------------------------
   initial
   begin
      memBusPkg::memAddrT addr;
      void'($urandom(32'h5a69_9c2b));
      Reset      = 1'b1;
      psel       = 1'b0;
      penable    = 1'b0;
      pwrite     = 1'b0;
      paddr      = '0;
      pwdata     = '0;
      pstrb      = '0;
      testNo     = 0;
      testChecks = 0;
      testErrs   = 0;
      repeat (ResetCycles) @(posedge Clk);
      Reset <= 1'b0;

      for (int i = 0; i < lc3IsaPkg::BootWords; i++)
         readWord(memBusPkg::memAddrT'(i));
      for (int i = 0; i < BootSamples; i++)
         readWord(memBusPkg::memAddrT'(lc3IsaPkg::BootWords
                  + int'($urandom % (Depth - lc3IsaPkg::BootWords))));
      readWord(memBusPkg::memAddrT'(Depth - 1));
      reportTest("boot image");

      for (int i = 0; i < FullWrites; i++)
      begin
         addr = memBusPkg::memAddrT'($urandom % WritableWords);
         writeWord(addr, memBusPkg::memWordT'($urandom), 2'b11);
         readWord(addr);
      end
      reportTest("full-word write");

      for (int i = 0; i < StrbWords; i++)
      begin
         addr = memBusPkg::memAddrT'(3*i + 5);       // Some boot words among them
         writeWord(addr, 16'hA5C3 ^ memBusPkg::memWordT'(i), 2'b11);
         writeWord(addr, memBusPkg::memWordT'($urandom), 2'b01);
         readWord(addr);
         writeWord(addr, memBusPkg::memWordT'($urandom), 2'b10);
         readWord(addr);
      end
      reportTest("byte-lane write");

      tryLockedWrite(memBusPkg::memAddrT'(WritableWords));
      tryLockedWrite(memBusPkg::memAddrT'(WritableWords + 7));
      tryLockedWrite(memBusPkg::memAddrT'(Depth - 1));
      tryLockedWrite(memBusPkg::memAddrT'(Depth + 3));
      reportTest("write outside window");

      readWord(memBusPkg::memAddrT'(Depth));
      readWord(memBusPkg::memAddrT'(Depth + 100));
      readWord(16'hFFFF);
      reportTest("read beyond array");

      for (int i = 0; i < RandomOps; i++)
      begin
         if ($urandom % 4 == 0)
            addr = memBusPkg::memAddrT'($urandom % (Depth + 16));
         else
            addr = memBusPkg::memAddrT'($urandom % WritableWords);
         if ($urandom % 2 == 0)
            readWord(addr);
         else
            writeWord(addr, memBusPkg::memWordT'($urandom), memBusPkg::byteStrbT'($urandom));
      end
      reportTest("random mix");

      pulseReset();
      for (int i = 0; i < AfterReset; i++)
         readWord(memBusPkg::memAddrT'(i));
      reportTest("reset restores boot image");

      $display("checks %0d of %0d, errors %0d", checkTotal, NumTransfers, errTotal);
      if (checkTotal != NumTransfers)
         $display("scoreboard saw a different number of transfers than were driven");
      if (errTotal == 0 && checkTotal == NumTransfers)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

   initial
   begin
      #(TimeoutNs);
      $display("watchdog expired after %0d ns with the test sequence still running", TimeoutNs);
      $display("tests failed");
      $finish;
   end

endmodule

//--- dv/memScoreboard.sv
// APB monitor with model array, reference function for the expected response and check counters

`timescale 1ns/100ps

module memScoreboard
#(
   parameter int Depth         = 256,                // Words in the array
   parameter int WritableWords = 64                  // Low words open to writes
)
(
   input  logic                Clk,
   input  logic                Reset,
   input  logic                psel,
   input  logic                penable,
   input  logic                pwrite,
   input  memBusPkg::memAddrT  paddr,
   input  memBusPkg::memWordT  pwdata,
   input  memBusPkg::byteStrbT pstrb,
   input  memBusPkg::memWordT  prdata,
   input  logic                pready,
   input  logic                pslverr,
   output int                  checkCount,
   output int                  errCount
);

   localparam int IdxBits = (Depth > 1) ? $clog2(Depth) : 1;

   memBusPkg::memWordT model [Depth];                // Expected array contents
   memBusPkg::memReqT  cap;                          // Transfer seen in setup
   memBusPkg::memRspT  expRsp;
   int                 cycleNo = 0;                  // Cycle inside transfer, 0 when idle
   int                 checks  = 0;
   int                 errs    = 0;

   assign checkCount = checks;
   assign errCount   = errs;

   // ------------------------------------------------------------
   // Reference model
   // ------------------------------------------------------------
   function automatic memBusPkg::memRspT expectRsp(input memBusPkg::memReqT xfer);
      memBusPkg::memRspT rsp;
      rsp.rdata = '0;                                // Writes return no data
      rsp.err   = 1'b0;
      if (xfer.write)
         rsp.err = int'(xfer.addr) >= WritableWords; // Outside the write window
      else if (int'(xfer.addr) < Depth)
         rsp.rdata = model[xfer.addr[IdxBits-1:0]];  // Whole word, never masked
      else
         rsp.err = 1'b1;                             // Beyond the array
      return rsp;
   endfunction

   function automatic void applyWrite(input memBusPkg::memReqT xfer);
      if (int'(xfer.addr) < WritableWords)
      begin
         for (int b = 0; b < memBusPkg::WordBytes; b++)
         begin
            if (xfer.strb[b])
               model[xfer.addr[IdxBits-1:0]][8*b +: 8] = xfer.wdata[8*b +: 8];
         end
      end
   endfunction

   // ------------------------------------------------------------
   // Port monitor, sampled on the rising edge
   // ------------------------------------------------------------
   always @(posedge Clk or posedge Reset)
   begin
      if (Reset)
      begin
         for (int i = 0; i < Depth; i++)
            model[i] = lc3IsaPkg::bootImage(i);      // Boot words, zero above
         cycleNo = 0;
      end
      else
      begin
         if (!pready && (prdata !== '0 || pslverr !== 1'b0))
         begin
            $display("FAILED %0d ns: prdata %h pslverr %b while pready low",
                     $time, prdata, pslverr);
            errs++;
         end
         if (psel && !penable)
         begin
            cap = '{valid: 1'b1, write: pwrite, addr: paddr, wdata: pwdata, strb: pstrb};
            cycleNo = 1;                             // Setup cycle
         end
         else if (psel && penable && cycleNo > 0)
         begin
            cycleNo++;
            if (pready)
            begin
               if (cycleNo != 3)
               begin
                  $display("pready came in cycle %0d instead of cycle 3 at %0d ns",
                           cycleNo, $time);
                  errs++;
               end
               expRsp = expectRsp(cap);
               checks++;
               if (prdata !== expRsp.rdata || pslverr !== expRsp.err)
               begin
                  $display("FAILED %0d ns: %s addr %h got %h/%b expected %h/%b", $time,
                           cap.write ? "write" : "read", cap.addr, prdata, pslverr,
                           expRsp.rdata, expRsp.err);
                  errs++;
               end
               if (cap.write)
                  applyWrite(cap);                   // Model follows the write
               cycleNo = 0;
            end
            else if (cycleNo == 3)
            begin
               $display("pready missing in the third cycle of the transfer to %h at %0d ns",
                        cap.addr, $time);
               errs++;
            end
         end
         else if (pready)
         begin
            $display("pready raised with no transfer in its access phase at %0d ns", $time);
            errs++;
         end
      end
   end

endmodule

//--- source/sramTestMemory.sv
// Top level of the APB test memory, front end and memory core with shared parameters

`timescale 1ns/100ps

module sramTestMemory
#(
   parameter int Depth         = 256,                // Words in the array
   parameter int WritableWords = 64                  // Writable low words
)
(
   input  logic                Clk,
   input  logic                Reset,
   input  logic                psel,
   input  logic                penable,
   input  logic                pwrite,
   input  memBusPkg::memAddrT  paddr,
   input  memBusPkg::memWordT  pwdata,
   input  memBusPkg::byteStrbT pstrb,
   output memBusPkg::memWordT  prdata,
   output logic                pready,
   output logic                pslverr
);

   memBusPkg::memReqT req;                           // Front end to core
   memBusPkg::memRspT rsp;                           // Core back to front end

   apbFrontEnd frontEnd
   (
      .Clk     (Clk),
      .Reset   (Reset),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .pstrb   (pstrb),
      .req     (req),
      .rsp     (rsp),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr)
   );

   memCore #(.Depth(Depth), .WritableWords(WritableWords)) core
   (
      .Clk   (Clk),
      .Reset (Reset),
      .req   (req),
      .rsp   (rsp)
   );

endmodule

//--- source/memCore.sv
// Word memory with boot preload on reset, write window check, byte-lane writes and registered read

`timescale 1ns/100ps

module memCore
#(
   parameter int Depth         = 256,                // Words in the array
   parameter int WritableWords = 64                  // Low words open to writes
)
(
   input  logic              Clk,
   input  logic              Reset,
   input  memBusPkg::memReqT req,
   output memBusPkg::memRspT rsp
);

   localparam int IdxBits = (Depth > 1) ? $clog2(Depth) : 1;

   memBusPkg::memWordT memArray [Depth];             // Storage

   logic               inRange;                      // Address below Depth
   logic               inWindow;                     // Address below WritableWords
   logic [IdxBits-1:0] idx;                          // Array index

   // ------------------------------------------------------------
   // Address decode
   // ------------------------------------------------------------
   assign inRange  = int'(req.addr) < Depth;
   assign inWindow = int'(req.addr) < WritableWords;
   assign idx      = req.addr[IdxBits-1:0];          // Only trusted when inRange

   // ------------------------------------------------------------
   // Array update
   // ------------------------------------------------------------
   always_ff @(posedge Clk or posedge Reset)
   begin
      if (Reset)
      begin
         for (int i = 0; i < Depth; i++)
            memArray[i] <= lc3IsaPkg::bootImage(i);  // Boot words, zero above
      end
      else if (req.valid && req.write && inWindow)
      begin
         for (int b = 0; b < memBusPkg::WordBytes; b++)
         begin
            if (req.strb[b])
               memArray[idx][8*b +: 8] <= req.wdata[8*b +: 8]; // Strobed lanes only
         end
      end
   end

   // ------------------------------------------------------------
   // Response register
   // ------------------------------------------------------------
   always_ff @(posedge Clk)
   begin
      if (req.valid)
      begin
         if (req.write)
         begin
            rsp.rdata <= '0;
            rsp.err   <= !inWindow;                  // Read-only or missing word
         end
         else if (inRange)
         begin
            rsp.rdata <= memArray[idx];              // Full word, no lane masking
            rsp.err   <= 1'b0;
         end
         else
         begin
            rsp.rdata <= '0;
            rsp.err   <= 1'b1;                       // Beyond the array
         end
      end
   end

   // Write window has to sit inside the array
   windowFits: assert property (@(posedge Clk) WritableWords <= Depth)
      else $error("WritableWords %0d exceeds Depth %0d", WritableWords, Depth);

endmodule

//--- source/apbFrontEnd.sv
// APB slave FSM that captures a transfer, issues one core request and returns the response

`timescale 1ns/100ps

module apbFrontEnd
(
   input  logic                Clk,
   input  logic                Reset,
   input  logic                psel,
   input  logic                penable,
   input  logic                pwrite,
   input  memBusPkg::memAddrT  paddr,
   input  memBusPkg::memWordT  pwdata,
   input  memBusPkg::byteStrbT pstrb,
   output memBusPkg::memReqT   req,
   input  memBusPkg::memRspT   rsp,
   output memBusPkg::memWordT  prdata,
   output logic                pready,
   output logic                pslverr
);

   typedef enum logic [1:0]
   {
      IDLE,                                          // Waiting for a setup cycle
      ACCESS,                                        // First access cycle, request out
      RESPOND                                        // Second access cycle, pready high
   } apbStateT;

   apbStateT state;
   apbStateT nextState;

   logic                setupSeen;                   // Setup phase on the bus
   logic                reqWrite;
   memBusPkg::memAddrT  reqAddr;
   memBusPkg::memWordT  reqWdata;
   memBusPkg::byteStrbT reqStrb;

   assign setupSeen = psel && !penable;

   // ------------------------------------------------------------
   // Transfer FSM
   // ------------------------------------------------------------
   always_comb
   begin
      nextState = state;
      case (state)
         IDLE:
         begin
            if (setupSeen)
               nextState = ACCESS;
         end
         ACCESS:  nextState = RESPOND;               // Fixed single wait state
         RESPOND: nextState = IDLE;
         default: nextState = IDLE;
      endcase
   end

   always_ff @(posedge Clk or posedge Reset)
   begin
      if (Reset)
         state <= IDLE;
      else
         state <= nextState;
   end

   // Transfer fields latched at the end of setup
   always_ff @(posedge Clk)
   begin
      if (state == IDLE && setupSeen)
      begin
         reqWrite <= pwrite;
         reqAddr  <= paddr;
         reqWdata <= pwdata;
         reqStrb  <= pstrb;
      end
   end

   assign req = '{valid: (state == ACCESS),          // Pulse in first access cycle
                  write: reqWrite,
                  addr:  reqAddr,
                  wdata: reqWdata,
                  strb:  reqStrb};

   // ------------------------------------------------------------
   // APB response
   // ------------------------------------------------------------
   assign pready  = (state == RESPOND);
   assign prdata  = pready ? rsp.rdata : '0;         // Zero outside the ready cycle
   assign pslverr = pready && rsp.err;

   // Access phase must come straight from a setup phase
   setupBeforeAccess: assert property (@(posedge Clk) disable iff (Reset)
      $rose(penable) |-> $past(psel && !penable))
      else $error("penable rose without a setup cycle");

   addrStable: assert property (@(posedge Clk) disable iff (Reset)
      psel && penable && !pready |=> $stable(paddr))
      else $error("paddr changed during wait state");

   // Ready cycle closes the access phase
   readyPulse: assert property (@(posedge Clk) disable iff (Reset)
      pready |=> !penable)
      else $error("penable held past the ready cycle");

endmodule

//--- source/lc3IsaPkg.sv
// LC-3 opcode enum, register type, instruction encoders, I/O offset and the boot image function

package lc3IsaPkg;

   // ------------------------------------------------------------
   // Opcodes and operands
   // ------------------------------------------------------------
   typedef enum logic [3:0]
   {
      BR   = 4'b0000,                                // Conditional branch
      ADD  = 4'b0001,
      LD   = 4'b0010,
      ST   = 4'b0011,
      JSR  = 4'b0100,                                // Subroutine call, saves PC in R7
      AND  = 4'b0101,
      LDR  = 4'b0110,                                // Base plus offset load
      STR  = 4'b0111,                                // Base plus offset store
      RTI  = 4'b1000,
      NOT  = 4'b1001,
      LDI  = 4'b1010,
      STI  = 4'b1011,
      JMP  = 4'b1100,
      RES  = 4'b1101,                                // Reserved in the base ISA
      LEA  = 4'b1110,
      TRAP = 4'b1111
   } opcodeT;

   localparam opcodeT PSE = RES;                     // Pause takes the reserved slot

   typedef logic [2:0] regT;                         // Register number

   // Registers named by the boot image
   localparam regT R0 = 3'd0;
   localparam regT R1 = 3'd1;
   localparam regT R2 = 3'd2;
   localparam regT R7 = 3'd7;

   localparam logic [2:0] CondNzp = 3'b111;          // Branch always
   localparam int IoOffset = -1;                     // R0 + (-1) gives FFFF, switches and hex

   // ------------------------------------------------------------
   // Instruction encoders
   // ------------------------------------------------------------
   function automatic memBusPkg::memWordT opCLR(input regT dr);
      return {AND, dr, dr, 1'b1, 5'b00000};          // AND with immediate zero
   endfunction

   function automatic memBusPkg::memWordT opINC(input regT dr);
      return {ADD, dr, dr, 1'b1, 5'b00001};          // ADD immediate one
   endfunction

   function automatic memBusPkg::memWordT opLDR(input regT dr, input regT baseR,
                                                input int offset6);
      return {LDR, dr, baseR, offset6[5:0]};
   endfunction

   function automatic memBusPkg::memWordT opSTR(input regT sr, input regT baseR,
                                                input int offset6);
      return {STR, sr, baseR, offset6[5:0]};
   endfunction

   function automatic memBusPkg::memWordT opJMP(input regT baseR);
      return {JMP, 3'b000, baseR, 6'b000000};
   endfunction

   function automatic memBusPkg::memWordT opBR(input logic [2:0] cond, input int offset9);
      return {BR, cond, offset9[8:0]};               // PC relative
   endfunction

   function automatic memBusPkg::memWordT opPSE(input logic [11:0] code);
      return {PSE, code};                            // Upper nibble selects LED checkpoint mode
   endfunction

   function automatic memBusPkg::memWordT opJSR(input int offset11);
      return {JSR, 1'b1, offset11[10:0]};            // PC relative form
   endfunction

   // ------------------------------------------------------------
   // Boot image
   // ------------------------------------------------------------
   localparam int BootWords = 20;

   function automatic memBusPkg::memWordT bootImage(input int idx);
      memBusPkg::memWordT word;
      word = '0;
      if (idx < BootWords)
      begin
         case (idx)
            0:  word = opCLR(R0);                    // Zero base for I/O
            1:  word = opLDR(R1, R0, IoOffset);      // Switches pick a program
            2:  word = opJMP(R1);
            3:  word = opLDR(R1, R0, IoOffset);      // I/O test 1
            4:  word = opSTR(R1, R0, IoOffset);      // Echo to hex
            5:  word = opBR(CondNzp, -3);
            6:  word = opPSE(12'h801);               // I/O test 2, wait for input
            7:  word = opLDR(R1, R0, IoOffset);
            8:  word = opSTR(R1, R0, IoOffset);
            9:  word = opPSE(12'hC02);               // Show output, wait again
            10: word = opBR(CondNzp, -4);
            11: word = opPSE(12'h801);               // I/O test 3, self-modifying
            12: word = opJSR(0);                     // R7 gets own PC
            13: word = opLDR(R2, R7, 3);             // Pause word read as data
            14: word = opLDR(R1, R0, IoOffset);
            15: word = opSTR(R1, R0, IoOffset);
            16: word = opPSE(12'hC02);               // Word patched by the loop
            17: word = opINC(R2);                    // Next checkpoint number
            18: word = opSTR(R2, R7, 3);             // Write back over word 16
            19: word = opBR(CondNzp, -6);
            default: word = '0;
         endcase
      end
      return word;
   endfunction

endpackage

//--- source/memBusPkg.sv
// Memory word, address and strobe types plus the front end to core request and response structs

package memBusPkg;

   // ------------------------------------------------------------
   // Basic widths
   // ------------------------------------------------------------
   localparam int WordBytes = 2;                     // Bytes per memory word

   typedef logic [8*WordBytes-1:0] memWordT;         // One memory word
   typedef logic [15:0]            memAddrT;         // Word address, not byte address
   typedef logic [WordBytes-1:0]   byteStrbT;        // Bit 1 is upper byte

   // ------------------------------------------------------------
   // Front end to core transfer
   // ------------------------------------------------------------
   typedef struct packed
   {
      logic     valid;                               // One-cycle request pulse
      logic     write;                               // 1 write, 0 read
      memAddrT  addr;                                // Target word
      memWordT  wdata;                               // Write payload
      byteStrbT strb;                                // Byte lanes to update
   } memReqT;

   // Core answer, one cycle after the request
   typedef struct packed
   {
      memWordT rdata;                                // Read word, zero on writes
      logic    err;                                  // Out of range or read-only
   } memRspT;

endpackage
